// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vram_subsys
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/vram.sv ====
// vram: single-port synchronous VRAM with nibble write mask and power-up test pattern
`timescale 1ns/1ps

module vram #(
    parameter int ADDR_W = 16
) (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [vram_pkg::MASK_W-1:0] wr_mask,
    input  logic [ADDR_W-1:0]           address_in,
    input  logic [vram_pkg::WORD_W-1:0] data_in,
    output logic [vram_pkg::WORD_W-1:0] data_out
);

    localparam int DEPTH  = 2 ** ADDR_W;
    localparam int NIB_W  = vram_pkg::NIB_W;
    localparam int LO_W   = vram_pkg::PAT_LO_W;
    localparam int HI_W   = vram_pkg::PAT_HI_W;

    logic [vram_pkg::WORD_W-1:0] mem [0:DEPTH-1];

    // predictable contents before the first write
    initial begin
        logic [LO_W-1:0] lo;
        logic [HI_W-1:0] hi;
        for (int i = 0; i < DEPTH; i++) begin
            lo = i[LO_W-1:0];
            hi = {~lo[LO_W-1 -: NIB_W], lo[LO_W-1 -: NIB_W]};
            mem[i] = {hi, lo};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int n = 0; n < vram_pkg::MASK_W; n++) begin
                if (wr_mask[n]) begin
                    mem[address_in][n*NIB_W +: NIB_W] <= data_in[n*NIB_W +: NIB_W];
                end
            end
        end
        data_out <= mem[address_in];  // old word on a write cycle
    end

    // a write to an unknown address would silently corrupt some word
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en |-> !$isunknown(address_in)
    ) else $error("vram write with unknown address");

endmodule

// ==== hw/vram_engine.sv ====
// vram_engine: FSM running masked write, read and fill commands on the VRAM port
`timescale 1ns/1ps

module vram_engine #(
    parameter int ADDR_W = 16
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  vram_regs_pkg::opcode_e             op,
    input  logic [ADDR_W-1:0]                  base_addr,
    input  logic [vram_pkg::WORD_W-1:0]        wr_data,
    input  logic [vram_pkg::MASK_W-1:0]        wr_mask,
    input  logic [vram_regs_pkg::COUNT_W-1:0]  count,
    output logic                               busy,
    output logic                               done,
    output logic [vram_pkg::WORD_W-1:0]        rd_data,
    output logic                               rd_valid,
    output logic                               mem_wr_en,
    output logic [vram_pkg::MASK_W-1:0]        mem_mask,
    output logic [ADDR_W-1:0]                  mem_addr,
    output logic [vram_pkg::WORD_W-1:0]        mem_wdata,
    input  logic [vram_pkg::WORD_W-1:0]        mem_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ_ADDR,
        READ_CAP,
        FILL,
        DONE
    } state_e;

    state_e                              state;
    logic [ADDR_W-1:0]                   cur_addr;   // wraps at the top of VRAM
    logic [vram_regs_pkg::COUNT_W-1:0]   remaining;  // fill words still to write
    logic [vram_pkg::WORD_W-1:0]         cmd_data;
    logic [vram_pkg::MASK_W-1:0]         cmd_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            cur_addr  <= '0;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        cur_addr  <= base_addr;
                        remaining <= count;
                        case (op)
                            vram_regs_pkg::OP_WRITE: state <= WRITE;
                            vram_regs_pkg::OP_READ:  state <= READ_ADDR;
                            vram_regs_pkg::OP_FILL: begin
                                if (count == '0) state <= DONE;  // empty fill
                                else state <= FILL;
                            end
                            default: state <= DONE;
                        endcase
                    end
                end
                WRITE:     state <= DONE;
                READ_ADDR: state <= READ_CAP;  // RAM output lands next cycle
                READ_CAP:  state <= DONE;
                FILL: begin
                    cur_addr  <= cur_addr + 1'b1;
                    remaining <= remaining - 1'b1;
                    if (remaining == 1) state <= DONE;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // command payload, held for the whole operation
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cmd_data <= wr_data;
            cmd_mask <= wr_mask;
        end
    end

    assign busy      = (state != IDLE);
    assign done      = (state == DONE);
    assign rd_valid  = (state == READ_CAP);
    assign rd_data   = mem_rdata;
    assign mem_wr_en = (state == WRITE) || (state == FILL);
    assign mem_mask  = cmd_mask;
    assign mem_addr  = cur_addr;
    assign mem_wdata = cmd_data;

    // the register block must hold off commands while an operation runs
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    ) else $error("start while engine busy");

endmodule

// ==== hw/vram_pkg.sv ====
// vram_pkg: VRAM word width, nibble write mask width, test-pattern field widths
package vram_pkg;

    localparam int WORD_W = 16;              // bits per VRAM word
    localparam int MASK_W = 4;               // one write enable per nibble
    localparam int NIB_W  = WORD_W / MASK_W; // bits covered by one mask bit

    // test pattern: {~a[7:4], a[7:4], a[7:0]}
    localparam int PAT_LO_W = 8;             // low address byte copied as is

    // sanity on the pattern layout
    // the upper byte is two copies of one address nibble
    localparam int PAT_HI_W = WORD_W - PAT_LO_W;

endpackage

// ==== hw/vram_regs.sv ====
// vram_regs: AXI4-Lite register slave for VRAM access parameters, command issue and status
`timescale 1ns/1ps

module vram_regs #(
    parameter int ADDR_W = 16
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [vram_regs_pkg::AXI_ADDR_W-1:0]     awaddr,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  logic [vram_regs_pkg::AXI_DATA_W-1:0]     wdata,
    input  logic [vram_regs_pkg::AXI_DATA_W/8-1:0]   wstrb,   // unused, full-word writes
    input  logic                                     wvalid,
    output logic                                     wready,
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  logic                                     bready,
    input  logic [vram_regs_pkg::AXI_ADDR_W-1:0]     araddr,
    input  logic                                     arvalid,
    output logic                                     arready,
    output logic [vram_regs_pkg::AXI_DATA_W-1:0]     rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  logic                                     rready,
    output logic                                     start,
    output vram_regs_pkg::opcode_e                   op,
    output logic [ADDR_W-1:0]                        base_addr,
    output logic [vram_pkg::WORD_W-1:0]              wr_data,
    output logic [vram_pkg::MASK_W-1:0]              wr_mask,
    output logic [vram_regs_pkg::COUNT_W-1:0]        count,
    input  logic                                     busy,
    input  logic                                     done,
    input  logic [vram_pkg::WORD_W-1:0]              rd_data,
    input  logic                                     rd_valid
);

    localparam int AW = vram_regs_pkg::AXI_ADDR_W;

    vram_regs_pkg::reg_index_e wr_idx;
    vram_regs_pkg::reg_index_e rd_idx;
    vram_regs_pkg::opcode_e    cmd_op;
    logic                      wr_hs;
    logic                      rd_hs;
    logic                      cmd_pend;  // command issued, engine not yet done
    logic [1:0]                wr_resp;
    logic [1:0]                rd_resp;
    logic [vram_pkg::WORD_W-1:0]          rd_word;  // last OP_READ result
    logic [vram_regs_pkg::AXI_DATA_W-1:0] rd_mux;

    assign wr_idx = vram_regs_pkg::reg_index_e'(awaddr[AW-1:2]);
    assign rd_idx = vram_regs_pkg::reg_index_e'(araddr[AW-1:2]);
    assign cmd_op = vram_regs_pkg::opcode_e'(wdata[1:0]);
    assign wr_hs  = awready && wready && awvalid && wvalid;
    assign rd_hs  = arready && arvalid;

    // write response: busy engine rejects CMD, holes in the map reject everything
    always_comb begin
        wr_resp = vram_regs_pkg::RESP_OKAY;
        case (wr_idx)
            vram_regs_pkg::REG_CMD: begin
                if (busy || cmd_pend) wr_resp = vram_regs_pkg::RESP_SLVERR;
            end
            vram_regs_pkg::REG_ADDR, vram_regs_pkg::REG_DATA, vram_regs_pkg::REG_MASK,
            vram_regs_pkg::REG_COUNT, vram_regs_pkg::REG_STATUS: wr_resp = vram_regs_pkg::RESP_OKAY;
            default: wr_resp = vram_regs_pkg::RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_mux  = '0;
        rd_resp = vram_regs_pkg::RESP_OKAY;
        case (rd_idx)
            vram_regs_pkg::REG_ADDR:   rd_mux[ADDR_W-1:0] = base_addr;
            vram_regs_pkg::REG_DATA:   rd_mux[vram_pkg::WORD_W-1:0] = rd_word;
            vram_regs_pkg::REG_MASK:   rd_mux[vram_pkg::MASK_W-1:0] = wr_mask;
            vram_regs_pkg::REG_COUNT:  rd_mux[vram_regs_pkg::COUNT_W-1:0] = count;
            vram_regs_pkg::REG_CMD:    rd_mux[1:0] = op;  // last issued opcode
            vram_regs_pkg::REG_STATUS: rd_mux[0] = busy;
            default:                   rd_resp = vram_regs_pkg::RESP_SLVERR;
        endcase
    end

    // write channel, parameter registers and command issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= vram_regs_pkg::RESP_OKAY;
            start     <= 1'b0;
            cmd_pend  <= 1'b0;
            op        <= vram_regs_pkg::OP_NOP;
            base_addr <= '0;
            wr_data   <= '0;
            wr_mask   <= '0;
            count     <= '0;
        end else begin
            start   <= 1'b0;
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (done) cmd_pend <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
                case (wr_idx)
                    vram_regs_pkg::REG_ADDR:  base_addr <= wdata[ADDR_W-1:0];
                    vram_regs_pkg::REG_DATA:  wr_data   <= wdata[vram_pkg::WORD_W-1:0];
                    vram_regs_pkg::REG_MASK:  wr_mask   <= wdata[vram_pkg::MASK_W-1:0];
                    vram_regs_pkg::REG_COUNT: count     <= wdata[vram_regs_pkg::COUNT_W-1:0];
                    vram_regs_pkg::REG_CMD: begin
                        if (wr_resp == vram_regs_pkg::RESP_OKAY &&
                            cmd_op != vram_regs_pkg::OP_NOP) begin
                            start    <= 1'b1;
                            cmd_pend <= 1'b1;
                            op       <= cmd_op;
                        end
                    end
                    default: ;  // STATUS is read only
                endcase
            end
        end
    end

    // read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= vram_regs_pkg::RESP_OKAY;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rvalid && rready) rvalid <= 1'b0;
            if (rd_hs) begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
                rresp  <= rd_resp;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rd_word <= '0;
        else if (rd_valid) rd_word <= rd_data;  // engine capture strobe
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("rvalid dropped or changed before rready");

endmodule

// ==== hw/vram_regs_pkg.sv ====
// vram_regs_pkg: register index map, engine opcodes, AXI4-Lite widths and response codes
package vram_regs_pkg;

    localparam int AXI_ADDR_W = 5;   // 8 word slots, 6 used
    localparam int AXI_DATA_W = 32;
    localparam int COUNT_W    = 16;  // fill length register

    // register index = byte address / 4
    typedef enum logic [2:0] {
        REG_ADDR   = 3'd0,  // 0x00
        REG_DATA   = 3'd1,  // 0x04
        REG_MASK   = 3'd2,  // 0x08
        REG_COUNT  = 3'd3,  // 0x0C
        REG_CMD    = 3'd4,  // 0x10
        REG_STATUS = 3'd5   // 0x14, bit 0 busy
    } reg_index_e;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_FILL  = 2'd3
    } opcode_e;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/vram_subsys.sv ====
// vram_subsys: top level joining the AXI4-Lite register block, access engine and VRAM
`timescale 1ns/1ps

module vram_subsys #(
    parameter int ADDR_W = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [vram_regs_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [vram_regs_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic [vram_regs_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [vram_regs_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [vram_regs_pkg::AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready
);

    logic                              start, busy, done, rd_valid;
    vram_regs_pkg::opcode_e            op;
    logic [ADDR_W-1:0]                 base_addr, mem_addr;
    logic [vram_pkg::WORD_W-1:0]       wr_data, rd_data, mem_wdata, mem_rdata;
    logic [vram_pkg::MASK_W-1:0]       wr_mask, mem_mask;
    logic [vram_regs_pkg::COUNT_W-1:0] count;
    logic                              mem_wr_en;

    vram_regs #(.ADDR_W(ADDR_W)) regs_i (.*);  // host side plus command strobes

    vram_engine #(.ADDR_W(ADDR_W)) engine_i (.*);

    vram #(.ADDR_W(ADDR_W)) vram_i (
        .clk(clk), .wr_en(mem_wr_en), .wr_mask(mem_mask), .address_in(mem_addr),
        .data_in(mem_wdata), .data_out(mem_rdata)
    );

endmodule

// ==== testbench/tb_vram_subsys.sv ====
// tb_vram_subsys: clock, reset, AXI4-Lite driver tasks, stimulus table, checks and report
`timescale 1ns/1ps

module tb_vram_subsys;

    localparam int ADDR_W   = 16;
    localparam int TIMEOUT  = 50;   // cycles allowed per handshake wait
    localparam int POLL_MAX = 400;  // status reads before the engine counts as stuck
    localparam logic [1:0] OKAY   = vram_regs_pkg::RESP_OKAY;
    localparam logic [1:0] SLVERR = vram_regs_pkg::RESP_SLVERR;
    localparam int R_ADDR  = vram_regs_pkg::REG_ADDR;
    localparam int R_DATA  = vram_regs_pkg::REG_DATA;
    localparam int R_MASK  = vram_regs_pkg::REG_MASK;
    localparam int R_COUNT = vram_regs_pkg::REG_COUNT;
    localparam int R_CMD   = vram_regs_pkg::REG_CMD;
    localparam int R_STAT  = vram_regs_pkg::REG_STATUS;

    typedef enum int {A_WR, A_RD, A_PEEK, A_IDLE} action_e;

    logic        clk, rst_n;
    logic [4:0]  awaddr, araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;

    // stimulus table, one entry per test
    string       t_name[$];
    action_e     t_act[$];
    logic [4:0]  t_reg[$];
    logic [31:0] t_val[$];
    logic [31:0] t_exp[$];
    logic [1:0]  t_resp[$];

    int errors;
    int passed;
    int failed;
    bit timed_out;

    vram_subsys #(.ADDR_W(ADDR_W)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // power-up word: {~a[7:4], a[7:4], a[7:0]}
    function automatic logic [31:0] pattern(input logic [ADDR_W-1:0] a);
        return {16'h0, ~a[7:4], a[7:4], a[7:0]};
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [15:0] new_w,
                                          input logic [3:0] mask);
        logic [31:0] res;
        res = old_w;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) res[n*4 +: 4] = new_w[n*4 +: 4];
        end
        return res;
    endfunction

    function automatic logic [4:0] reg_at(input int idx);
        return 5'(idx * 4);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        resp = 2'bxx;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(awready && wready) && n < TIMEOUT);
        if (!(awready && wready)) begin
            timed_out = 1'b1;
            $display("timeout: no awready and wready for write to 0x%02h", addr);
            return;
        end
        @(negedge clk);  // handshake edge has passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            timed_out = 1'b1;
            $display("timeout: no write response for 0x%02h", addr);
            return;
        end
        repeat ($urandom % 4) @(negedge clk);  // random bready stall
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        data = 'x;
        resp = 2'bxx;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arready && n < TIMEOUT);
        if (!arready) begin
            timed_out = 1'b1;
            $display("timeout: no arready for read of 0x%02h", addr);
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            timed_out = 1'b1;
            $display("timeout: no read data for 0x%02h", addr);
            return;
        end
        repeat ($urandom % 4) @(negedge clk);  // random rready stall
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic poll_idle();
        logic [31:0] data;
        logic [1:0]  resp;
        int          tries;
        tries = 0;
        do begin
            axi_read(reg_at(R_STAT), data, resp);
            tries++;
        end while (data[0] !== 1'b0 && !timed_out && tries < POLL_MAX);
        if (data[0] !== 1'b0 && !timed_out) begin
            timed_out = 1'b1;
            $display("timeout: engine still busy after %0d status reads", tries);
        end
    endtask

    // one OP_READ through the register block
    task automatic peek(input logic [31:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
        logic [1:0] r_addr;
        logic [1:0] r_cmd;
        axi_write(reg_at(R_ADDR), addr, r_addr);
        axi_write(reg_at(R_CMD), 32'(vram_regs_pkg::OP_READ), r_cmd);
        poll_idle();
        axi_read(reg_at(R_DATA), data, resp);
        if (r_addr !== OKAY) resp = r_addr;
        if (r_cmd !== OKAY) resp = r_cmd;
    endtask

    task automatic add_row(input string name, input action_e act, input int idx,
                           input logic [31:0] val, input logic [31:0] exp,
                           input logic [1:0] resp);
        t_name.push_back(name);
        t_act.push_back(act);
        t_reg.push_back(reg_at(idx));
        t_val.push_back(val);
        t_exp.push_back(exp);
        t_resp.push_back(resp);
    endtask

    task automatic add_peek(input string name, input logic [31:0] addr,
                            input logic [31:0] exp);
        add_row(name, A_PEEK, 0, addr, exp, OKAY);
    endtask

    // loads base, data, mask and count, then issues OP_FILL
    task automatic add_fill(input string name, input logic [31:0] base,
                            input logic [31:0] data, input logic [31:0] mask,
                            input logic [31:0] cnt);
        add_row({name, "_addr"}, A_WR, R_ADDR, base, 0, OKAY);
        add_row({name, "_data"}, A_WR, R_DATA, data, 0, OKAY);
        add_row({name, "_mask"}, A_WR, R_MASK, mask, 0, OKAY);
        add_row({name, "_count"}, A_WR, R_COUNT, cnt, 0, OKAY);
        add_row({name, "_cmd"}, A_WR, R_CMD, 32'(vram_regs_pkg::OP_FILL), 0, OKAY);
    endtask

    task automatic build_table();
        add_peek("pat_0000", 32'h0000, pattern(16'h0000));
        add_peek("pat_1234", 32'h1234, pattern(16'h1234));
        add_peek("pat_ffff", 32'hFFFF, pattern(16'hFFFF));
        // masked single write
        add_row("wr_addr", A_WR, R_ADDR, 32'h0055, 0, OKAY);
        add_row("wr_data", A_WR, R_DATA, 32'hBEEF, 0, OKAY);
        add_row("wr_mask", A_WR, R_MASK, 32'h5, 0, OKAY);
        add_row("wr_cmd", A_WR, R_CMD, 32'(vram_regs_pkg::OP_WRITE), 0, OKAY);
        add_row("wr_idle", A_IDLE, 0, 0, 0, OKAY);
        add_peek("wr_merge", 32'h0055, merge(pattern(16'h0055), 16'hBEEF, 4'h5));
        add_fill("fill", 32'h0200, 32'h1357, 32'hF, 32'd5);
        add_row("fill_idle", A_IDLE, 0, 0, 0, OKAY);
        add_peek("fill_first", 32'h0200, 32'h1357);
        add_peek("fill_last", 32'h0204, 32'h1357);
        add_peek("fill_after", 32'h0205, pattern(16'h0205));
        add_peek("fill_before", 32'h01FF, pattern(16'h01FF));
        add_fill("wrap", 32'hFFFE, 32'hC3A5, 32'hC, 32'd4);
        add_row("wrap_idle", A_IDLE, 0, 0, 0, OKAY);
        add_peek("wrap_top", 32'hFFFE, merge(pattern(16'hFFFE), 16'hC3A5, 4'hC));
        add_peek("wrap_low", 32'h0001, merge(pattern(16'h0001), 16'hC3A5, 4'hC));
        add_peek("wrap_after", 32'h0002, pattern(16'h0002));
        add_fill("zero", 32'h0300, 32'h0000, 32'hF, 32'd0);
        add_row("zero_idle", A_IDLE, 0, 0, 0, OKAY);
        add_peek("zero_untouched", 32'h0300, pattern(16'h0300));
        // register widths and map holes
        add_row("trunc_addr_wr", A_WR, R_ADDR, 32'hABCDE123, 0, OKAY);
        add_row("trunc_addr_rd", A_RD, R_ADDR, 0, 32'h0000E123, OKAY);
        add_row("trunc_mask_wr", A_WR, R_MASK, 32'hFFFFFFF6, 0, OKAY);
        add_row("trunc_mask_rd", A_RD, R_MASK, 0, 32'h6, OKAY);
        add_row("trunc_count_wr", A_WR, R_COUNT, 32'h12345678, 0, OKAY);
        add_row("trunc_count_rd", A_RD, R_COUNT, 0, 32'h5678, OKAY);
        add_row("status_idle", A_RD, R_STAT, 0, 32'h0, OKAY);
        add_row("bad_wr_idx6", A_WR, 6, 32'h1, 0, SLVERR);
        add_row("bad_rd_idx7", A_RD, 7, 0, 0, SLVERR);
        // command while a long fill runs
        add_fill("busy", 32'h1000, 32'hAAAA, 32'hF, 32'd200);
        add_row("busy_new_addr", A_WR, R_ADDR, 32'h3000, 0, OKAY);
        add_row("busy_cmd_reject", A_WR, R_CMD, 32'(vram_regs_pkg::OP_WRITE), 0, SLVERR);
        add_row("busy_status", A_RD, R_STAT, 0, 32'h1, OKAY);
        add_row("busy_idle", A_IDLE, 0, 0, 0, OKAY);
        add_peek("busy_no_write", 32'h3000, pattern(16'h3000));
        add_peek("busy_fill_last", 32'h10C7, 32'hAAAA);
        add_peek("busy_fill_after", 32'h10C8, pattern(16'h10C8));
    endtask

    task automatic run_row(input int i);
        logic [31:0] data;
        logic [1:0]  resp;
        int          errs_before;
        errs_before = errors;
        data = '0;
        resp = OKAY;
        case (t_act[i])
            A_WR:    axi_write(t_reg[i], t_val[i], resp);
            A_RD:    axi_read(t_reg[i], data, resp);
            A_PEEK:  peek(t_val[i], data, resp);
            default: poll_idle();
        endcase
        if (timed_out) begin
            failed++;
            $display("%s: timed out", t_name[i]);
            return;
        end
        if ((t_act[i] == A_RD || t_act[i] == A_PEEK) && t_resp[i] == OKAY) begin
            check(t_name[i], t_exp[i], data);
        end
        if (t_act[i] != A_IDLE) begin
            check({t_name[i], " resp"}, 32'(t_resp[i]), 32'(resp));
        end
        if (errors == errs_before) begin
            passed++;
            $display("%s: ok", t_name[i]);
        end else begin
            failed++;
            $display("%s: failed", t_name[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h10319d66));
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hF;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < t_name.size() && !timed_out; i++) begin
            run_row(i);
        end
        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (errors == 0 && failed == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/vram_pkg.sv
hw/vram_regs_pkg.sv
hw/vram.sv
hw/vram_regs.sv
hw/vram_engine.sv
hw/vram_subsys.sv
testbench/tb_vram_subsys.sv
